// ==== fcvt_cfg.svh ====
`ifndef FCVT_CFG_SVH
`define FCVT_CFG_SVH

// single-precision target format
`define FCVT_EXP_BITS   8
`define FCVT_MAN_BITS   23   // stored bits, hidden one not counted
`define FCVT_EXP_BIAS   127

// integer operand
`define FCVT_INT_W      32
`define FCVT_LZC_W      5    // enough to count 0..31 leading zeros

// request tag carried alongside each operation
`define FCVT_TAG_W      4

// lanes per request unless overridden at the top
`define FCVT_NUM_LANES  2

`endif

// ==== filelist.f ====
+incdir+.
logic/fcvt_pkg.sv
logic/fcvt_pipe_reg.sv
logic/fcvt_lzc.sv
logic/fcvt_normalize.sv
logic/fcvt_round.sv
logic/fcvt_itof.sv
sim/fcvt_checker.sv
sim/tb_fcvt.sv

// ==== logic/fcvt_itof.sv ====
`default_nettype none

`include "fcvt_cfg.svh"

module fcvt_itof #(
    parameter int NUM_LANES = `FCVT_NUM_LANES
) (
    input  wire                                    clk,
    input  wire                                    rst_i,

    input  wire                                    valid_i,
    output logic                                   ready_o,
    input  wire  [`FCVT_TAG_W-1:0]                 tag_i,
    input  wire  fcvt_pkg::frm_e                   frm_i,
    input  wire                                    is_signed_i,
    input  wire  [NUM_LANES-1:0][`FCVT_INT_W-1:0]  data_i,

    output logic                                   valid_o,
    input  wire                                    ready_i,
    output logic [`FCVT_TAG_W-1:0]                 tag_o,
    output logic [NUM_LANES-1:0][`FCVT_INT_W-1:0]  result_o,
    output fcvt_pkg::fflags_t [NUM_LANES-1:0]      fflags_o
);

    import fcvt_pkg::*;

    // per-stage payloads, valid bits travel separately in the registers
    typedef struct packed {
        tag_t                                 tag;
        frm_e                                 frm;
        logic                                 is_signed;
        logic [NUM_LANES-1:0][`FCVT_INT_W-1:0] data;
    } s0_t;

    typedef struct packed {
        tag_t                  tag;
        frm_e                  frm;
        norm_t [NUM_LANES-1:0] norm;
    } s1_t;

    typedef struct packed {
        tag_t                 tag;
        rnd_t [NUM_LANES-1:0] rnd;
    } s2_t;

    logic stall;
    logic pipe_en;

    logic s0_valid;
    logic s1_valid;
    s0_t  s0_d, s0_q;
    s1_t  s1_d, s1_q;
    s2_t  s2_d, s2_q;

    norm_t [NUM_LANES-1:0] norm_s0;   // cycle 1 result
    rnd_t  [NUM_LANES-1:0] rnd_s1;    // cycle 2 result

    // whole pipe freezes while the consumer holds off, bubbles included
    assign stall   = valid_o & ~ready_i;
    assign pipe_en = ~stall;
    assign ready_o = ~stall;

    assign s0_d = '{tag: tag_i, frm: frm_i, is_signed: is_signed_i, data: data_i};

    fcvt_pipe_reg #(.T(s0_t)) pipe_reg0 (
        .clk      (clk),
        .rst_i    (rst_i),
        .enable_i (pipe_en),
        .valid_i  (valid_i),
        .data_i   (s0_d),
        .valid_o  (s0_valid),
        .data_o   (s0_q)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_norm
        fcvt_normalize normalize_i (
            .data_i      (s0_q.data[i]),
            .is_signed_i (s0_q.is_signed),
            .norm_o      (norm_s0[i])
        );
    end

    assign s1_d = '{tag: s0_q.tag, frm: s0_q.frm, norm: norm_s0};

    fcvt_pipe_reg #(.T(s1_t)) pipe_reg1 (
        .clk      (clk),
        .rst_i    (rst_i),
        .enable_i (pipe_en),
        .valid_i  (s0_valid),
        .data_i   (s1_d),
        .valid_o  (s1_valid),
        .data_o   (s1_q)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_round
        fcvt_round round_i (
            .norm_i (s1_q.norm[i]),
            .frm_i  (s1_q.frm),
            .rnd_o  (rnd_s1[i])
        );
    end

    assign s2_d = '{tag: s1_q.tag, rnd: rnd_s1};

    fcvt_pipe_reg #(.T(s2_t)) pipe_reg2 (
        .clk      (clk),
        .rst_i    (rst_i),
        .enable_i (pipe_en),
        .valid_i  (s1_valid),
        .data_i   (s2_d),
        .valid_o  (valid_o),
        .data_o   (s2_q)
    );

    assign tag_o = s2_q.tag;

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            result_o[i] = s2_q.rnd[i].word;
            fflags_o[i] = s2_q.rnd[i].flags;
        end
    end

    // output side holds its data until the consumer takes it
    assert property (@(posedge clk) disable iff (rst_i)
        stall |=> ($stable(result_o) && $stable(tag_o)))
        else $error("fcvt_itof: output changed during stall");

    // only the five defined modes may reach the rounding stage
    assert property (@(posedge clk) disable iff (rst_i)
        s1_valid |-> (s1_q.frm <= RMM))
        else $error("fcvt_itof: illegal rounding mode in round stage");

endmodule

`default_nettype wire

// ==== logic/fcvt_lzc.sv ====
`default_nettype none

`include "fcvt_cfg.svh"

module fcvt_lzc (
    input  wire  [`FCVT_INT_W-1:0] data_i,
    output logic [`FCVT_LZC_W-1:0] count_o,
    output logic                   nonzero_o
);

    localparam int W  = `FCVT_INT_W;
    localparam int CW = `FCVT_LZC_W;

    logic [W-1:0] win;   // window shifted as zeros are found

    // binary search from the top, largest chunk first
    always_comb begin
        win     = data_i;
        count_o = '0;
        for (int l = CW - 1; l >= 0; l--) begin
            if ((win >> (W - (1 << l))) == '0) begin
                count_o[l] = 1'b1;          // top 2^l bits are empty
                win        = win << (1 << l);
            end
        end
    end

    // count reads 31 for zero input so zero needs its own flag
    assign nonzero_o = |data_i;

endmodule

`default_nettype wire

// ==== logic/fcvt_normalize.sv ====
`default_nettype none

`include "fcvt_cfg.svh"

module fcvt_normalize (
    input  wire  [`FCVT_INT_W-1:0] data_i,
    input  wire                    is_signed_i,
    output fcvt_pkg::norm_t        norm_o
);

    localparam int W   = `FCVT_INT_W;
    localparam int LZW = `FCVT_LZC_W;

    logic           sign;
    logic [W-1:0]   mag;
    logic [LZW-1:0] lz_cnt;
    logic           nonzero;

    assign sign = is_signed_i & data_i[W-1];

    // two's complement negate; 0x80000000 maps onto itself as 2^31
    assign mag = sign ? (~data_i + 1'b1) : data_i;

    fcvt_lzc lzc_i (
        .data_i    (mag),
        .count_o   (lz_cnt),
        .nonzero_o (nonzero)
    );

    assign norm_o = '{
        sign:    sign,
        is_zero: ~nonzero,
        exp:     LZW'(W - 1) - lz_cnt,   // unbiased exponent
        mant:    mag << lz_cnt
    };

    // lzc and shifter have to agree on where the leading one lands
    always_comb begin
        if (!norm_o.is_zero) begin
            assert (norm_o.mant[W-1])
                else $error("fcvt_normalize: leading one not in msb");
        end
    end

endmodule

`default_nettype wire

// ==== logic/fcvt_pipe_reg.sv ====
`default_nettype none

module fcvt_pipe_reg #(
    parameter type T = logic
) (
    input  wire  clk,
    input  wire  rst_i,
    input  wire  enable_i,
    input  wire  valid_i,
    input  wire  T data_i,
    output logic valid_o,
    output T     data_o
);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else if (enable_i) begin
            valid_o <= valid_i;
        end
    end

    // payload only matters when valid is set
    always_ff @(posedge clk) begin
        if (enable_i) begin
            data_o <= data_i;
        end
    end

    // a frozen stage must not lose or invent an operation
    assert property (@(posedge clk) disable iff (rst_i)
        !enable_i |=> $stable(valid_o))
        else $error("fcvt_pipe_reg: valid changed while stage was held");

endmodule

`default_nettype wire

// ==== logic/fcvt_pkg.sv ====
`default_nettype none

`include "fcvt_cfg.svh"

package fcvt_pkg;

    // rounding modes, RISC-V frm encoding
    typedef enum logic [2:0] {
        RNE = 3'd0,
        RTZ = 3'd1,
        RDN = 3'd2,
        RUP = 3'd3,
        RMM = 3'd4
    } frm_e;

    typedef struct packed {
        logic NV;   // invalid
        logic DZ;   // divide by zero
        logic OF;
        logic UF;
        logic NX;   // inexact
    } fflags_t;

    typedef logic [`FCVT_TAG_W-1:0] tag_t;

    // integer after normalization, one per lane
    typedef struct packed {
        logic                             sign;
        logic                             is_zero;
        logic [$clog2(`FCVT_INT_W)-1:0]   exp;    // position of the leading one
        logic [`FCVT_INT_W-1:0]           mant;   // leading one in the msb
    } norm_t;

    typedef struct packed {
        logic [`FCVT_EXP_BITS+`FCVT_MAN_BITS:0] word;
        fflags_t                                flags;
    } rnd_t;

endpackage

`default_nettype wire

// ==== logic/fcvt_round.sv ====
`default_nettype none

`include "fcvt_cfg.svh"

module fcvt_round (
    input  wire fcvt_pkg::norm_t norm_i,
    input  wire fcvt_pkg::frm_e  frm_i,
    output fcvt_pkg::rnd_t       rnd_o
);

    import fcvt_pkg::*;

    localparam int MW    = `FCVT_MAN_BITS;
    localparam int SIG_W = MW + 1;                     // hidden one included
    localparam int RB    = `FCVT_INT_W - SIG_W - 1;    // round bit position
    localparam int EXP_W = `FCVT_EXP_BITS;

    logic [SIG_W-1:0] sig;
    logic             round_bit;
    logic             sticky;
    logic             inexact;
    logic             round_up;
    logic [SIG_W:0]   sig_rnd;     // one extra bit for the carry
    logic             carry;
    logic [MW-1:0]    man;
    logic [EXP_W-1:0] exp_biased;

    assign sig       = norm_i.mant[`FCVT_INT_W-1 -: SIG_W];
    assign round_bit = norm_i.mant[RB];
    assign sticky    = |norm_i.mant[RB-1:0];
    assign inexact   = round_bit | sticky;

    always_comb begin
        case (frm_i)
            RNE:     round_up = round_bit & (sticky | sig[0]);   // ties to even
            RTZ:     round_up = 1'b0;
            RDN:     round_up = norm_i.sign & inexact;
            RUP:     round_up = ~norm_i.sign & inexact;
            RMM:     round_up = round_bit;                       // ties away
            default: round_up = 1'b0;
        endcase
    end

    assign sig_rnd = {1'b0, sig} + {{SIG_W{1'b0}}, round_up};

    // all ones roll over into 1.0 at the next exponent
    assign carry = sig_rnd[SIG_W];
    assign man   = carry ? '0 : sig_rnd[MW-1:0];

    // at most 32 + 127 so never reaches the inf encoding
    assign exp_biased = EXP_W'(norm_i.exp) + EXP_W'(carry) + EXP_W'(`FCVT_EXP_BIAS);

    always_comb begin
        rnd_o = '0;                  // integer zero gives +0.0
        if (!norm_i.is_zero) begin
            rnd_o.word     = {norm_i.sign, exp_biased, man};
            rnd_o.flags.NX = inexact;
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build the fcvt testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_fcvt -f filelist.f \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/Vtb_fcvt > sim.log 2>&1 || echo "simulator exited with an error"

grep -q "TB FAILED" sim.log && { cat sim.log; echo "simulation failed"; exit 1; }
grep -q "TB PASSED" sim.log || { cat sim.log; echo "no verdict in sim.log"; exit 1; }
tail -n 7 sim.log && echo "simulation passed"

// ==== sim/fcvt_checker.sv ====
`default_nettype none

`include "fcvt_cfg.svh"

module fcvt_checker #(
    parameter int LANES = `FCVT_NUM_LANES
) (
    input  wire                                clk,
    input  wire                                rst_i,
    input  wire                                req_valid_i,
    input  wire                                req_ready_i,
    input  wire  [`FCVT_TAG_W-1:0]             req_tag_i,
    input  wire  [2:0]                         frm_i,
    input  wire                                is_signed_i,
    input  wire  [LANES-1:0][`FCVT_INT_W-1:0]  data_i,
    input  wire                                res_valid_i,
    input  wire                                res_ready_i,
    input  wire  [`FCVT_TAG_W-1:0]             res_tag_i,
    input  wire  [LANES-1:0][`FCVT_INT_W-1:0]  result_i,
    input  wire  [LANES-1:0][4:0]              fflags_i,
    input  wire  [3:0]                         test_id_i,
    input  wire                                test_done_i,
    input  wire                                final_i,
    output int                                 pending_o,
    output int                                 errors_o
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int EW = `FCVT_TAG_W + LANES * 37;   // tag on top, word+flags per lane

    logic [EW-1:0] exp_q[$];
    logic          rst_q = 1'b0;
    int            checks = 0;
    int            test_checks = 0;
    int            test_errs = 0;

    // reference conversion, returns word and {NV, DZ, OF, UF, NX}
    function automatic logic [36:0] model(input logic [31:0] d, input logic sgn,
                                          input logic [2:0] mode);
        logic        neg;
        logic [63:0] mag;
        logic [63:0] sig;
        logic [63:0] rem;
        logic [63:0] half;
        logic        up;
        int          p;
        neg = sgn & d[31];
        mag = neg ? 64'h1_0000_0000 - {32'd0, d} : {32'd0, d};
        if (mag == 64'd0) begin
            return 37'd0;
        end
        p = 0;
        for (int i = 0; i < 64; i++) begin
            if (mag[i]) begin
                p = i;   // position of the leading one
            end
        end
        sig  = (p > 23) ? mag >> (p - 23) : mag << (23 - p);
        rem  = (p > 23) ? mag & ((64'd1 << (p - 23)) - 64'd1) : 64'd0;
        half = (p > 23) ? 64'd1 << (p - 24) : 64'd0;
        case (mode)
            3'd0:    up = (rem > half) || (rem == half && rem != 0 && sig[0]);
            3'd2:    up = neg && rem != 0;
            3'd3:    up = !neg && rem != 0;
            3'd4:    up = rem != 0 && rem >= half;
            default: up = 1'b0;   // truncate
        endcase
        sig = sig + 64'(up);
        if (sig[24]) begin   // rolled over to the next power of two
            sig = sig >> 1;
            p   = p + 1;
        end
        return {neg, 8'(p + 127), sig[22:0], 4'd0, rem != 0};
    endfunction

    task automatic count_error();
        errors_o++;
        test_errs++;
    endtask

    task automatic compare_result();
        logic [EW-1:0] want;
        if (exp_q.size() == 0) begin
            $display("result with tag %h arrived with no request outstanding", res_tag_i);
            count_error();
            return;
        end
        want = exp_q.pop_front();
        checks++;
        test_checks++;
        if (res_tag_i !== want[EW-1 -: `FCVT_TAG_W]) begin
            $display("Mismatch tag_o: got %h expected %h", res_tag_i, want[EW-1 -: `FCVT_TAG_W]);
            count_error();
        end
        for (int l = 0; l < LANES; l++) begin
            if (result_i[l] !== want[l*37+5 +: 32]) begin
                $display("Mismatch result_o[%0d] tag %h: got %h expected %h",
                         l, res_tag_i, result_i[l], want[l*37+5 +: 32]);
                count_error();
            end
            if (fflags_i[l] !== want[l*37 +: 5]) begin
                $display("Mismatch fflags_o[%0d] tag %h: got %h expected %h",
                         l, res_tag_i, fflags_i[l], want[l*37 +: 5]);
                count_error();
            end
        end
    endtask

    task automatic push_expected();
        logic [EW-1:0] ent;
        ent[EW-1 -: `FCVT_TAG_W] = req_tag_i;
        for (int l = 0; l < LANES; l++) begin
            ent[l*37 +: 37] = model(data_i[l], is_signed_i, frm_i);
        end
        exp_q.push_back(ent);
    endtask

    always @(posedge clk) begin
        rst_q <= rst_i;
        if (rst_q) begin   // reset seen at the previous edge, outputs idle
            checks++;
            test_checks++;
            if (res_valid_i !== 1'b0) begin
                $display("Mismatch valid_o after reset: got %h expected 0", res_valid_i);
                count_error();
            end
            if (req_ready_i !== 1'b1) begin
                $display("Mismatch ready_o after reset: got %h expected 1", req_ready_i);
                count_error();
            end
        end
        if (!rst_i && res_valid_i && res_ready_i) begin
            compare_result();
        end
        if (!rst_i && req_valid_i && req_ready_i) begin
            push_expected();
        end
        pending_o = exp_q.size();
        if (test_done_i) begin
            $display("test %0d finished: %0d checks, %0d errors",
                     test_id_i, test_checks, test_errs);
            test_checks = 0;
            test_errs   = 0;
        end
        if (final_i) begin
            if (exp_q.size() != 0) begin
                $display("expected queue not empty at end: %0d results never arrived",
                         exp_q.size());
                count_error();
            end
            $display("total: %0d checks, %0d errors", checks, errors_o);
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_fcvt.sv ====
`default_nettype none

`include "fcvt_cfg.svh"

module tb_fcvt;
    timeunit 1ns;
    timeprecision 100ps;

    import fcvt_pkg::*;

    localparam int LANES       = `FCVT_NUM_LANES;
    localparam int N_RANDOM    = 2000;
    localparam int N_REQ       = 37 * 10 + 42 * 10 + 2 * N_RANDOM;
    localparam int CYCLE_LIMIT = 8 * N_REQ + 100;
    localparam int DRAIN_LIMIT = 100;   // cycles for the pipe to empty

    logic                               clk = 1'b0;
    logic                               rst_i;
    logic                               valid_i;
    logic                               ready_o;
    logic [`FCVT_TAG_W-1:0]             tag_i;
    frm_e                               frm_i;
    logic                               is_signed_i;
    logic [LANES-1:0][`FCVT_INT_W-1:0]  data_i;
    logic                               valid_o;
    logic                               ready_i;
    logic [`FCVT_TAG_W-1:0]             tag_o;
    logic [LANES-1:0][`FCVT_INT_W-1:0]  result_o;
    fflags_t [LANES-1:0]                fflags_o;
    logic [3:0]                         test_id;
    logic                               test_done;
    logic                               final_chk;
    int                                 pending;
    int                                 errors;
    int                                 seed;
    int                                 cycles = 0;
    bit                                 bp_on;

    always #2 clk = ~clk;

    fcvt_itof dut_i (
        .clk         (clk),
        .rst_i       (rst_i),
        .valid_i     (valid_i),
        .ready_o     (ready_o),
        .tag_i       (tag_i),
        .frm_i       (frm_i),
        .is_signed_i (is_signed_i),
        .data_i      (data_i),
        .valid_o     (valid_o),
        .ready_i     (ready_i),
        .tag_o       (tag_o),
        .result_o    (result_o),
        .fflags_o    (fflags_o)
    );

    fcvt_checker #(.LANES(LANES)) checker_i (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_valid_i (valid_i),
        .req_ready_i (ready_o),
        .req_tag_i   (tag_i),
        .frm_i       (frm_i),
        .is_signed_i (is_signed_i),
        .data_i      (data_i),
        .res_valid_i (valid_o),
        .res_ready_i (ready_i),
        .res_tag_i   (tag_o),
        .result_i    (result_o),
        .fflags_i    (fflags_o),
        .test_id_i   (test_id),
        .test_done_i (test_done),
        .final_i     (final_chk),
        .pending_o   (pending),
        .errors_o    (errors)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic logic [31:0] directed_value(input int v);
        case (v)
            0:       return 32'd0;
            1:       return 32'd1;
            2:       return 32'hFFFF_FFFF;   // -1 as signed
            3:       return 32'h8000_0000;
            4:       return 32'hFFFF_FFFF;
            default: return 32'd1 << (v - 5);
        endcase
    endfunction

    // significand 0x800000 or 0xFFFFFF with the bits below at, above or below half
    function automatic logic [31:0] boundary_mag(input int p, input int kind, input logic odd);
        logic [31:0] sig;
        logic [31:0] half;
        sig  = odd ? 32'hFF_FFFF : 32'h80_0000;
        half = 32'd1 << (p - 24);
        case (kind)
            0:       return (sig << (p - 23)) | half;
            1:       return (sig << (p - 23)) | (half + 32'd1);
            default: return (sig << (p - 23)) | (half - 32'd1);
        endcase
    endfunction

    task automatic tick();
        logic [31:0] r;
        @(posedge clk);
        if (bp_on) begin
            r = rand32();
            ready_i <= r[0];
        end else begin
            ready_i <= 1'b1;
        end
    endtask

    task automatic send_req(input logic [31:0] d0, input logic [31:0] d1,
                            input logic [2:0] mode, input logic sgn);
        logic [LANES-1:0][`FCVT_INT_W-1:0] d;
        logic [31:0]                       r;
        for (int l = 0; l < LANES; l++) begin
            d[l] = (l == 0) ? d0 : d1;
        end
        r = rand32();
        while (r[1:0] == 2'd0) begin   // idle one cycle in four
            valid_i <= 1'b0;
            tick();
            r = rand32();
        end
        valid_i     <= 1'b1;
        tag_i       <= r[8 +: `FCVT_TAG_W];
        frm_i       <= frm_e'(mode);
        is_signed_i <= sgn;
        data_i      <= d;
        tick();
        while (!ready_o) begin
            tick();
        end
    endtask

    task automatic run_random(input int n);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            a = rand32();
            b = rand32();
            r = rand32();
            send_req(a, b, 3'(r[30:0] % 31'd5), r[31]);
        end
    endtask

    // wait for outstanding results, giving up after DRAIN_LIMIT cycles
    task automatic drain();
        int waited;
        valid_i <= 1'b0;
        waited = 0;
        do begin
            tick();
            @(negedge clk);
            waited++;
        end while (pending != 0 && waited < DRAIN_LIMIT);
        tick();
    endtask

    task automatic end_test(input logic [3:0] n);
        test_id   <= n;
        test_done <= 1'b1;
        tick();
        test_done <= 1'b0;
    endtask

    initial begin
        logic [31:0] mag;
        logic [31:0] r;
        seed        = 63;
        bp_on       = 1'b0;
        rst_i       <= 1'b1;
        valid_i     <= 1'b0;
        tag_i       <= '0;
        frm_i       <= RNE;
        is_signed_i <= 1'b0;
        data_i      <= '0;
        ready_i     <= 1'b1;
        test_id     <= '0;
        test_done   <= 1'b0;
        final_chk   <= 1'b0;
        repeat (5) tick();
        rst_i <= 1'b0;
        tick();                          // first cycle out of reset still checked
        end_test(4'd1);
        for (int v = 0; v < 37; v++) begin
            for (int m = 0; m < 10; m++) begin
                send_req(directed_value(v), -directed_value(v), 3'(m % 5), m >= 5);
            end
        end
        drain();
        end_test(4'd2);
        for (int p = 25; p < 32; p++) begin
            for (int k = 0; k < 6; k++) begin
                mag = boundary_mag(p, k % 3, k >= 3);
                for (int m = 0; m < 10; m++) begin
                    r = rand32();
                    send_req((m >= 5) ? -mag : mag, r, 3'(m % 5), m >= 5);
                end
            end
        end
        drain();
        end_test(4'd3);
        run_random(N_RANDOM);
        drain();
        end_test(4'd4);
        bp_on = 1'b1;                    // consumer now stalls at random
        run_random(N_RANDOM);
        drain();
        bp_on = 1'b0;
        end_test(4'd5);
        final_chk <= 1'b1;
        tick();
        final_chk <= 1'b0;
        @(negedge clk);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
